// ==== compile.f ====
+incdir+rtl
rtl/exu_pkg.sv
rtl/md_if.sv
rtl/exu_alu.sv
rtl/exu_multiplier.sv
rtl/exu_divider.sv
rtl/exu_core.sv
rtl/exu_top.sv
verification/exu_tb.sv

// ==== rtl/exu_alu.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"
`default_nettype none

module exu_alu (
	input  wire exu_pkg::alu_op_t alu_op,
	input  wire exu_pkg::word_t   a_data,
	input  wire exu_pkg::word_t   b_data,
	input  wire                   branch,
	input  wire [2:0]             funct3,
	output exu_pkg::word_t        result
);

	localparam int XLEN    = `EXU_XLEN;
	localparam int SHAMT_W = $clog2(`EXU_XLEN);

	logic               sub_mode;
	logic [XLEN:0]      sum_ext;
	exu_pkg::word_t     sum;
	logic               lt_signed;
	logic               lt_unsigned;
	logic               equal;
	logic               cond;
	logic [SHAMT_W-1:0] shamt;

	// ================================================
	// Shared adder-subtractor
	// ================================================
	assign sub_mode = branch ||
		(alu_op inside {exu_pkg::op_sub, exu_pkg::op_slt, exu_pkg::op_sltu});
	assign sum_ext = {1'b0, a_data} + {1'b0, (sub_mode ? ~b_data : b_data)} +
		{{XLEN{1'b0}}, sub_mode};
	assign sum = sum_ext[XLEN-1:0];

	assign lt_unsigned = !sum_ext[XLEN]; // No carry out means borrow
	assign lt_signed   = (a_data[XLEN-1] != b_data[XLEN-1]) ? a_data[XLEN-1] : sum[XLEN-1];
	assign equal       = (sum == '0);
	assign shamt       = b_data[SHAMT_W-1:0];

	// Branch condition, RISC-V funct3 coding
	always_comb begin
		case (funct3)
			3'b000:  cond = equal;
			3'b001:  cond = !equal;
			3'b100:  cond = lt_signed;
			3'b101:  cond = !lt_signed;
			3'b110:  cond = lt_unsigned;
			3'b111:  cond = !lt_unsigned;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		if (branch) begin
			result = {{(XLEN-1){1'b0}}, cond};
		end else begin
			case (alu_op)
				exu_pkg::op_add,
				exu_pkg::op_sub:  result = sum;
				exu_pkg::op_sll:  result = a_data << shamt;
				exu_pkg::op_slt:  result = {{(XLEN-1){1'b0}}, lt_signed};
				exu_pkg::op_sltu: result = {{(XLEN-1){1'b0}}, lt_unsigned};
				exu_pkg::op_xor:  result = a_data ^ b_data;
				exu_pkg::op_srl:  result = a_data >> shamt;
				exu_pkg::op_sra:  result = $signed(a_data) >>> shamt;
				exu_pkg::op_or:   result = a_data | b_data;
				exu_pkg::op_and:  result = a_data & b_data;
				default:          result = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/exu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_core (
	input  wire                   clock,
	input  wire                   reset,
	input  wire exu_pkg::word_t   pc,
	input  wire exu_pkg::word_t   src1,
	input  wire exu_pkg::word_t   src2,
	input  wire exu_pkg::word_t   imm,
	input  wire exu_pkg::unit_t   unit,
	input  wire exu_pkg::alu_op_t alu_op,
	input  wire exu_pkg::src_sel_t src_sel,
	input  wire [2:0]             funct3,
	input  wire                   id_to_ex,
	input  wire                   ex_to_wb,
	output logic                  exu_stall,
	output logic                  exu_finished,
	output exu_pkg::word_t        exu_result,
	output logic                  zero_flag
);

	exu_pkg::word_t   op_a;
	exu_pkg::word_t   op_b;
	exu_pkg::word_t   a_q;
	exu_pkg::word_t   b_q;
	exu_pkg::word_t   alu_result;
	exu_pkg::unit_t   unit_q;
	exu_pkg::alu_op_t alu_op_q;
	logic [2:0]       funct3_q;
	logic             is_branch;
	logic             is_md;
	logic             alu_pending;
	logic             issue_ok;

	md_if mul_bus ();
	md_if div_bus ();

	assign issue_ok = id_to_ex && !exu_stall && !exu_finished && !alu_pending;
	assign is_md    = (unit == exu_pkg::unit_mul) || (unit == exu_pkg::unit_div);

	// ================================================
	// Operand select and issue latch
	// ================================================
	always_comb begin
		case (src_sel)
			exu_pkg::sel_rs1_rs2: begin
				op_a = src1;
				op_b = src2;
			end
			exu_pkg::sel_rs1_imm: begin
				op_a = src1;
				op_b = imm;
			end
			exu_pkg::sel_pc_4: begin
				op_a = pc;
				op_b = exu_pkg::word_t'(4);
			end
			default: begin
				op_a = pc;
				op_b = imm;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (issue_ok) begin
			a_q      <= op_a;
			b_q      <= op_b;
			unit_q   <= unit;
			alu_op_q <= alu_op;
			funct3_q <= funct3;
		end
	end

	assign is_branch = (unit_q == exu_pkg::unit_branch);

	exu_alu u_alu (
		.alu_op (alu_op_q),
		.a_data (a_q),
		.b_data (b_q),
		.branch (is_branch),
		.funct3 (funct3_q),
		.result (alu_result)
	);

	assign mul_bus.a_data = a_q;
	assign mul_bus.b_data = b_q;
	assign mul_bus.funct3 = funct3_q;
	assign div_bus.a_data = a_q;
	assign div_bus.b_data = b_q;
	assign div_bus.funct3 = funct3_q;

	exu_multiplier u_mul (
		.clock (clock),
		.reset (reset),
		.md    (mul_bus)
	);

	exu_divider u_div (
		.clock (clock),
		.reset (reset),
		.md    (div_bus)
	);

	// ================================================
	// Dispatch, busy tracking and result buffer
	// ================================================
	always_ff @(posedge clock) begin
		if (reset) begin
			alu_pending  <= 1'b0;
			mul_bus.req  <= 1'b0;
			div_bus.req  <= 1'b0;
			exu_stall    <= 1'b0;
			exu_finished <= 1'b0;
			exu_result   <= '0;
		end else begin
			alu_pending <= issue_ok && !is_md;
			mul_bus.req <= issue_ok && (unit == exu_pkg::unit_mul);
			div_bus.req <= issue_ok && (unit == exu_pkg::unit_div);

			if (issue_ok && is_md) begin
				exu_stall <= 1'b1;
			end else if (mul_bus.resp || div_bus.resp) begin
				exu_stall <= 1'b0;
			end

			if (alu_pending) begin
				exu_result   <= alu_result;
				exu_finished <= 1'b1;
			end else if (mul_bus.resp) begin
				exu_result   <= mul_bus.result;
				exu_finished <= 1'b1;
			end else if (div_bus.resp) begin
				exu_result   <= div_bus.result;
				exu_finished <= 1'b1;
			end else if (ex_to_wb) begin
				exu_finished <= 1'b0; // Writeback took the result
			end
		end
	end

	assign zero_flag = (exu_result == '0);

	issue_when_blocked: assert property (@(posedge clock) disable iff (reset)
		id_to_ex |-> (!exu_stall && !exu_finished))
		else $error("issue while the execute stage is stalled or holding a result");

	stall_finished_excl: assert property (@(posedge clock) disable iff (reset)
		!(exu_stall && exu_finished))
		else $error("stall and finished high together");

endmodule

`default_nettype wire

// ==== rtl/exu_divider.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"
`default_nettype none

module exu_divider (
	input wire clock,
	input wire reset,
	md_if.unit md
);

	localparam int XLEN  = `EXU_XLEN;
	localparam int CNT_W = $clog2(`EXU_MD_STEPS);

	exu_pkg::md_state_t state;
	logic [CNT_W-1:0]   count;
	exu_pkg::word_t     dividend_q;
	exu_pkg::word_t     divisor_q;
	exu_pkg::word_t     quo;
	exu_pkg::word_t     rem;
	exu_pkg::word_t     div_mag;
	logic               is_signed;
	logic               want_rem;
	logic               quo_neg;
	logic               rem_neg;
	logic               in_signed;
	logic               a_neg;
	logic               b_neg;
	logic [XLEN:0]      shifted;
	logic [XLEN:0]      diff;
	logic               div_zero;
	logic               overflow;
	exu_pkg::word_t     quo_out;
	exu_pkg::word_t     rem_out;

	assign in_signed = !md.funct3[0]; // div and rem
	assign a_neg     = in_signed && md.a_data[XLEN-1];
	assign b_neg     = in_signed && md.b_data[XLEN-1];

	// ================================================
	// Control
	// ================================================
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= exu_pkg::md_idle;
			count <= '0;
		end else begin
			case (state)
				exu_pkg::md_idle: begin
					if (md.req) begin
						state <= exu_pkg::md_run;
						count <= '0;
					end
				end
				exu_pkg::md_run: begin
					count <= count + 1'b1;
					if (count == CNT_W'(`EXU_MD_STEPS - 1)) begin
						state <= exu_pkg::md_done;
					end
				end
				default: state <= exu_pkg::md_idle;
			endcase
		end
	end

	// Restoring step on magnitudes, dividend shifts out of quo as quotient shifts in
	assign shifted = {rem, quo[XLEN-1]};
	assign diff    = shifted - {1'b0, div_mag};

	always_ff @(posedge clock) begin
		if (state == exu_pkg::md_idle && md.req) begin
			dividend_q <= md.a_data;
			divisor_q  <= md.b_data;
			quo        <= a_neg ? -md.a_data : md.a_data;
			div_mag    <= b_neg ? -md.b_data : md.b_data;
			rem        <= '0;
			is_signed  <= in_signed;
			want_rem   <= md.funct3[1];
			quo_neg    <= a_neg ^ b_neg;
			rem_neg    <= a_neg; // Remainder follows the dividend
		end else if (state == exu_pkg::md_run) begin
			if (!diff[XLEN]) begin
				rem <= diff[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b0};
			end
		end
	end

	// ================================================
	// Sign fix-up and RISC-V special cases
	// ================================================
	assign div_zero = (divisor_q == '0);
	assign overflow = is_signed && (dividend_q == {1'b1, {(XLEN-1){1'b0}}}) && (divisor_q == '1);

	always_comb begin
		quo_out = quo_neg ? -quo : quo;
		rem_out = rem_neg ? -rem : rem;
		if (div_zero) begin
			quo_out = '1;
			rem_out = dividend_q;
		end else if (overflow) begin
			quo_out = dividend_q;
			rem_out = '0;
		end
	end

	assign md.busy   = (state == exu_pkg::md_run);
	assign md.resp   = (state == exu_pkg::md_done);
	assign md.result = want_rem ? rem_out : quo_out;

	resp_single: assert property (@(posedge clock) disable iff (reset)
		md.resp |=> !md.resp)
		else $error("divider response held longer than one cycle");

endmodule

`default_nettype wire

// ==== rtl/exu_multiplier.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"
`default_nettype none

module exu_multiplier (
	input wire clock,
	input wire reset,
	md_if.unit md
);

	localparam int XLEN  = `EXU_XLEN;
	localparam int CNT_W = $clog2(`EXU_MD_STEPS);

	exu_pkg::md_state_t  state;
	logic [CNT_W-1:0]    count;
	logic [2*XLEN-1:0]   mcand;
	logic [2*XLEN-1:0]   product;
	logic [2*XLEN-1:0]   signed_prod;
	exu_pkg::word_t      mplier;
	exu_pkg::word_t      a_mag;
	exu_pkg::word_t      b_mag;
	logic                a_neg;
	logic                b_neg;
	logic                negate;
	logic                low_word;

	// mulh signed x signed, mulhsu signed x unsigned, mul and mulhu unsigned
	assign a_neg = ((md.funct3 == 3'b001) || (md.funct3 == 3'b010)) && md.a_data[XLEN-1];
	assign b_neg = (md.funct3 == 3'b001) && md.b_data[XLEN-1];
	assign a_mag = a_neg ? -md.a_data : md.a_data;
	assign b_mag = b_neg ? -md.b_data : md.b_data;

	// ================================================
	// Control
	// ================================================
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= exu_pkg::md_idle;
			count <= '0;
		end else begin
			case (state)
				exu_pkg::md_idle: begin
					if (md.req) begin
						state <= exu_pkg::md_run;
						count <= '0;
					end
				end
				exu_pkg::md_run: begin
					count <= count + 1'b1;
					if (count == CNT_W'(`EXU_MD_STEPS - 1)) begin
						state <= exu_pkg::md_done;
					end
				end
				default: state <= exu_pkg::md_idle; // Done lasts one cycle
			endcase
		end
	end

	// Shift-add datapath, one multiplier bit per cycle
	always_ff @(posedge clock) begin
		if (state == exu_pkg::md_idle && md.req) begin
			mcand    <= {{XLEN{1'b0}}, a_mag};
			mplier   <= b_mag;
			product  <= '0;
			negate   <= a_neg ^ b_neg;
			low_word <= (md.funct3 == 3'b000);
		end else if (state == exu_pkg::md_run) begin
			if (mplier[0]) begin
				product <= product + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign signed_prod = negate ? -product : product;

	assign md.busy   = (state == exu_pkg::md_run);
	assign md.resp   = (state == exu_pkg::md_done);
	assign md.result = low_word ? signed_prod[XLEN-1:0] : signed_prod[2*XLEN-1:XLEN];

	req_while_busy: assert property (@(posedge clock) disable iff (reset)
		md.req |-> (!md.busy && !md.resp))
		else $error("multiplier request while a product is in flight");

endmodule

`default_nettype wire

// ==== rtl/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`default_nettype none

// ================================================
// Execute stage sizing
// ================================================

// Data word width
`define EXU_XLEN 32

// Iteration cycles of the multiplier and the divider, one bit per cycle
`define EXU_MD_STEPS `EXU_XLEN

`default_nettype wire

`endif

// ==== rtl/exu_pkg.sv ====
`include "exu_params.svh"
`default_nettype none

package exu_pkg;

	typedef logic [`EXU_XLEN-1:0] word_t;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and
	} alu_op_t;

	typedef enum logic [1:0] {
		sel_rs1_rs2,
		sel_rs1_imm,
		sel_pc_4, // Link address
		sel_pc_imm
	} src_sel_t;

	typedef enum logic [1:0] {
		unit_alu,
		unit_branch,
		unit_mul,
		unit_div
	} unit_t;

	typedef enum logic [1:0] {
		md_idle,
		md_run,
		md_done
	} md_state_t;

endpackage

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top (
	input  wire                    clock,
	input  wire                    reset,
	input  wire exu_pkg::word_t    pc,
	input  wire exu_pkg::word_t    src1,
	input  wire exu_pkg::word_t    src2,
	input  wire exu_pkg::word_t    imm,
	input  wire exu_pkg::unit_t    unit,
	input  wire exu_pkg::alu_op_t  alu_op,
	input  wire exu_pkg::src_sel_t src_sel,
	input  wire [2:0]              funct3,
	input  wire                    id_to_ex,
	input  wire                    ex_to_wb,
	output logic                   exu_stall,
	output logic                   exu_finished,
	output exu_pkg::word_t         exu_result,
	output logic                   zero_flag
);

	exu_core u_core (
		.clock        (clock),
		.reset        (reset),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.unit         (unit),
		.alu_op       (alu_op),
		.src_sel      (src_sel),
		.funct3       (funct3),
		.id_to_ex     (id_to_ex),
		.ex_to_wb     (ex_to_wb),
		.exu_stall    (exu_stall),
		.exu_finished (exu_finished),
		.exu_result   (exu_result),
		.zero_flag    (zero_flag)
	);

endmodule

`default_nettype wire

// ==== rtl/md_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One multiply or divide request and its response
interface md_if;

	logic           req; // One-cycle pulse, only while not busy
	exu_pkg::word_t a_data;
	exu_pkg::word_t b_data;
	logic [2:0]     funct3;

	logic           busy;
	logic           resp; // One cycle, result valid
	exu_pkg::word_t result;

	modport requester (
		output req,
		output a_data,
		output b_data,
		output funct3,
		input  busy,
		input  resp,
		input  result
	);

	modport unit (
		input  req,
		input  a_data,
		input  b_data,
		input  funct3,
		output busy,
		output resp,
		output result
	);

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module exu_tb -o exu_sim \
	> sim.log 2>&1 \
	&& ./obj_dir/exu_sim >> sim.log 2>&1

grep -qF '*** TEST PASSED ***' sim.log \
	&& echo "Simulation passed, log in sim.log" \
	|| { echo "Simulation failed, log in sim.log"; exit 1; }

// ==== verification/exu_tb.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"
`default_nettype none

module exu_tb;

	localparam int XLEN           = `EXU_XLEN;
	localparam int FINISH_TIMEOUT = `EXU_MD_STEPS + 40;
	localparam exu_pkg::word_t MIN_WORD = {1'b1, {(`EXU_XLEN-1){1'b0}}};

	logic              clock;
	logic              reset;
	exu_pkg::word_t    pc;
	exu_pkg::word_t    src1;
	exu_pkg::word_t    src2;
	exu_pkg::word_t    imm;
	exu_pkg::unit_t    unit;
	exu_pkg::alu_op_t  alu_op;
	exu_pkg::src_sel_t src_sel;
	logic [2:0]        funct3;
	logic              id_to_ex;
	logic              ex_to_wb;
	logic              exu_stall;
	logic              exu_finished;
	exu_pkg::word_t    exu_result;
	logic              zero_flag;

	exu_pkg::word_t    expected_result; // Reference value of the instruction in flight
	integer            seed;
	int                instr_count;
	logic              alu_issue;
	logic              md_issue;
	exu_pkg::word_t    corners [4];
	logic [2:0]        branch_codes [6];

	exu_top u_dut (
		.clock        (clock),
		.reset        (reset),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.unit         (unit),
		.alu_op       (alu_op),
		.src_sel      (src_sel),
		.funct3       (funct3),
		.id_to_ex     (id_to_ex),
		.ex_to_wb     (ex_to_wb),
		.exu_stall    (exu_stall),
		.exu_finished (exu_finished),
		.exu_result   (exu_result),
		.zero_flag    (zero_flag)
	);

	always #4 clock = ~clock;

	assign alu_issue = id_to_ex && (unit == exu_pkg::unit_alu || unit == exu_pkg::unit_branch);
	assign md_issue  = id_to_ex && (unit == exu_pkg::unit_mul || unit == exu_pkg::unit_div);

	// ==================================================
	// Reference model
	// ==================================================
	function automatic exu_pkg::word_t alu_model(input exu_pkg::alu_op_t op,
		input exu_pkg::word_t a, input exu_pkg::word_t b);
		case (op)
			exu_pkg::op_add:  return a + b;
			exu_pkg::op_sub:  return a - b;
			exu_pkg::op_sll:  return a << b[4:0];
			exu_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exu_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
			exu_pkg::op_xor:  return a ^ b;
			exu_pkg::op_srl:  return a >> b[4:0];
			exu_pkg::op_sra:  return exu_pkg::word_t'($signed(a) >>> b[4:0]);
			exu_pkg::op_or:   return a | b;
			exu_pkg::op_and:  return a & b;
			default:          return '0;
		endcase
	endfunction

	function automatic logic branch_model(input logic [2:0] f3,
		input exu_pkg::word_t a, input exu_pkg::word_t b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			3'd7:    return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Low 64 bits of the product do not depend on signedness once operands are extended
	function automatic exu_pkg::word_t mul_model(input logic [2:0] f3,
		input exu_pkg::word_t a, input exu_pkg::word_t b);
		logic [2*XLEN-1:0] ext_a;
		logic [2*XLEN-1:0] ext_b;
		logic [2*XLEN-1:0] prod;
		ext_a = (f3 == 3'd1 || f3 == 3'd2) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
		ext_b = (f3 == 3'd1) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
		prod  = ext_a * ext_b;
		return (f3 == 3'd0) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
	endfunction

	function automatic exu_pkg::word_t div_model(input logic [2:0] f3,
		input exu_pkg::word_t a, input exu_pkg::word_t b);
		exu_pkg::word_t q;
		exu_pkg::word_t r;
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (!f3[0] && a == MIN_WORD && b == '1) begin
			q = a;
			r = '0;
		end else if (!f3[0]) begin
			q = exu_pkg::word_t'($signed(a) / $signed(b));
			r = exu_pkg::word_t'($signed(a) % $signed(b));
		end else begin
			q = a / b;
			r = a % b;
		end
		return f3[1] ? r : q;
	endfunction

	function automatic exu_pkg::word_t rand_word();
		return $random(seed);
	endfunction

	task stop_with_failure;
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Issue one instruction, wait for its result, then hand it to writeback after hold cycles
	task automatic run_instr(input exu_pkg::unit_t u, input exu_pkg::alu_op_t op,
		input exu_pkg::src_sel_t sel, input logic [2:0] f3, input exu_pkg::word_t pc_v,
		input exu_pkg::word_t s1, input exu_pkg::word_t s2, input exu_pkg::word_t imm_v,
		input int hold);
		exu_pkg::word_t a;
		exu_pkg::word_t b;
		int             waited;
		case (sel)
			exu_pkg::sel_rs1_rs2: begin
				a = s1;
				b = s2;
			end
			exu_pkg::sel_rs1_imm: begin
				a = s1;
				b = imm_v;
			end
			exu_pkg::sel_pc_4: begin
				a = pc_v;
				b = 32'd4;
			end
			default: begin
				a = pc_v;
				b = imm_v;
			end
		endcase
		@(negedge clock);
		case (u)
			exu_pkg::unit_alu:    expected_result = alu_model(op, a, b);
			exu_pkg::unit_branch: expected_result = {{(XLEN-1){1'b0}}, branch_model(f3, a, b)};
			exu_pkg::unit_mul:    expected_result = mul_model(f3, a, b);
			default:              expected_result = div_model(f3, a, b);
		endcase
		unit     = u;
		alu_op   = op;
		src_sel  = sel;
		funct3   = f3;
		pc       = pc_v;
		src1     = s1;
		src2     = s2;
		imm      = imm_v;
		id_to_ex = 1'b1;
		@(negedge clock);
		id_to_ex = 1'b0;
		waited   = 0;
		while (!exu_finished && waited < FINISH_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (!exu_finished) begin
			$display("Timed out waiting for exu_finished after instruction %0d", instr_count);
			stop_with_failure();
		end
		repeat (hold) @(negedge clock);
		ex_to_wb = 1'b1;
		@(negedge clock);
		ex_to_wb = 1'b0;
		instr_count++;
	endtask

	// ==================================================
	// Checks
	// ==================================================
	reset_clear: assert property (@(posedge clock)
		reset |=> (!exu_stall && !exu_finished && exu_result == '0))
		else begin
			$display("FAILED reset state exu_stall %h exu_finished %h exu_result %h",
				$sampled(exu_stall), $sampled(exu_finished), $sampled(exu_result));
			stop_with_failure();
		end

	result_match: assert property (@(posedge clock) disable iff (reset)
		$rose(exu_finished) |-> (exu_result == expected_result))
		else begin
			$display("FAILED exu_result expected %h actual %h",
				$sampled(expected_result), $sampled(exu_result));
			stop_with_failure();
		end

	zero_match: assert property (@(posedge clock) disable iff (reset)
		exu_finished |-> (zero_flag == (expected_result == '0)))
		else begin
			$display("FAILED zero_flag expected %h actual %h",
				$sampled(expected_result == '0), $sampled(zero_flag));
			stop_with_failure();
		end

	alu_first_cycle: assert property (@(posedge clock) disable iff (reset)
		alu_issue |=> (!exu_finished && !exu_stall))
		else begin
			$display("ALU result early or stall raised in the cycle after issue");
			stop_with_failure();
		end

	alu_second_cycle: assert property (@(posedge clock) disable iff (reset)
		$past(alu_issue, 2) |-> (exu_finished && !exu_stall))
		else begin
			$display("ALU result missing one cycle after the issue edge");
			stop_with_failure();
		end

	md_stalls: assert property (@(posedge clock) disable iff (reset)
		md_issue |=> exu_stall)
		else begin
			$display("exu_stall did not rise after a multiply or divide issue");
			stop_with_failure();
		end

	stall_until_result: assert property (@(posedge clock) disable iff (reset)
		$fell(exu_stall) |-> exu_finished)
		else begin
			$display("exu_stall dropped without a result arriving");
			stop_with_failure();
		end

	held_result: assert property (@(posedge clock) disable iff (reset)
		(exu_finished && !ex_to_wb) |=> (exu_finished && $stable(exu_result)))
		else begin
			$display("Result changed or finished dropped while writeback held off");
			stop_with_failure();
		end

	taken_result: assert property (@(posedge clock) disable iff (reset)
		(exu_finished && ex_to_wb) |=> !exu_finished)
		else begin
			$display("exu_finished stayed high after writeback took the result");
			stop_with_failure();
		end

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		int             i;
		int             j;
		int             f;
		exu_pkg::word_t w;
		clock           = 1'b0;
		reset           = 1'b1;
		pc              = '0;
		src1            = '0;
		src2            = '0;
		imm             = '0;
		unit            = exu_pkg::unit_alu;
		alu_op          = exu_pkg::op_add;
		src_sel         = exu_pkg::sel_rs1_rs2;
		funct3          = '0;
		id_to_ex        = 1'b0;
		ex_to_wb        = 1'b0;
		expected_result = '0;
		seed            = 19104;
		instr_count     = 0;
		corners[0]      = '0;
		corners[1]      = 32'd1;
		corners[2]      = '1;
		corners[3]      = MIN_WORD;
		branch_codes    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// Every ALU op with every operand source
		for (i = 0; i < 10; i++) begin
			for (j = 0; j < 4; j++) begin
				run_instr(exu_pkg::unit_alu, exu_pkg::alu_op_t'(i), exu_pkg::src_sel_t'(j), 3'd0,
					rand_word(), rand_word(), rand_word(), rand_word(), 0);
			end
		end
		w = rand_word();
		run_instr(exu_pkg::unit_alu, exu_pkg::op_sub, exu_pkg::sel_rs1_rs2, 3'd0, '0, w, w, '0, 0);
		run_instr(exu_pkg::unit_alu, exu_pkg::op_xor, exu_pkg::sel_rs1_imm, 3'd0, '0, w, '0, w, 0);

		for (i = 0; i < 6; i++) begin
			w = rand_word();
			run_instr(exu_pkg::unit_branch, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, branch_codes[i],
				'0, w, w, '0, 0);
			for (j = 0; j < 4; j++) begin
				run_instr(exu_pkg::unit_branch, exu_pkg::op_add, exu_pkg::sel_rs1_rs2,
					branch_codes[i], '0, rand_word(), rand_word(), '0, 0);
			end
			run_instr(exu_pkg::unit_branch, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, branch_codes[i],
				'0, rand_word() | MIN_WORD, rand_word() & ~MIN_WORD, '0, 0);
			run_instr(exu_pkg::unit_branch, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, branch_codes[i],
				'0, rand_word() & ~MIN_WORD, rand_word() | MIN_WORD, '0, 0);
		end

		for (f = 0; f < 4; f++) begin
			for (j = 0; j < 6; j++) begin
				run_instr(exu_pkg::unit_mul, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'(f),
					'0, rand_word(), rand_word(), '0, 0);
			end
			for (i = 0; i < 4; i++) begin
				for (j = 0; j < 4; j++) begin
					run_instr(exu_pkg::unit_mul, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'(f),
						'0, corners[i], corners[j], '0, 0);
				end
			end
		end

		// Corner pairs include zero divisors and the signed overflow case
		for (f = 4; f < 8; f++) begin
			for (j = 0; j < 6; j++) begin
				run_instr(exu_pkg::unit_div, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'(f),
					'0, rand_word(), rand_word() >> (j * 5), '0, 0);
			end
			run_instr(exu_pkg::unit_div, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'(f),
				'0, rand_word(), '0, '0, 0);
			for (i = 0; i < 4; i++) begin
				for (j = 0; j < 4; j++) begin
					run_instr(exu_pkg::unit_div, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'(f),
						'0, corners[i], corners[j], '0, 0);
				end
			end
		end

		// Writeback holds off for a random time
		for (i = 0; i < 6; i++) begin
			run_instr(exu_pkg::unit_alu, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'd0,
				'0, rand_word(), rand_word(), '0, 1 + ({$random(seed)} % 8));
		end
		run_instr(exu_pkg::unit_mul, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'd1,
			'0, rand_word(), rand_word(), '0, 1 + ({$random(seed)} % 8));
		run_instr(exu_pkg::unit_div, exu_pkg::op_add, exu_pkg::sel_rs1_rs2, 3'd4,
			'0, rand_word(), rand_word(), '0, 1 + ({$random(seed)} % 8));
		run_instr(exu_pkg::unit_alu, exu_pkg::op_and, exu_pkg::sel_pc_imm, 3'd0,
			rand_word(), '0, '0, rand_word(), 0);

		repeat (4) @(negedge clock);
		$display("Completed %0d instructions", instr_count);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
